//--- Makefile
VERILATOR ?= verilator
TOP ?= riscvTb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= TESTBENCH PASSED
FAIL_MSG ?= TESTBENCH FAILED

EXE := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/riscvTb.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscvTb;
	import riscvPkg::*;

	localparam int NUM_RAND = 60;
	localparam int HALT_IDX = 7 + NUM_RAND; // Seven preload ADDIs first
	localparam int PROG_WORDS = HALT_IDX + 1;
	localparam int TIMEOUT = 6 * PROG_WORDS + 50; // Worst case stalls plus pipeline fill

	logic CLK = 1'b0;
	logic RSTn = 1'b1; // Reset from time zero
	pcT iMemAddr;
	wordT iMemData, dMemRdData, rfRdData1, rfRdData2, numInst;
	dMemReqT dMemReq;
	regAddrT rfRdAddr1, rfRdAddr2;
	rfWriteT rfWrite;
	logic halt;

	wordT iMem [1 << (`PC_WIDTH - 2)];
	wordT dMem [1 << `DADDR_WIDTH]; // Memory seen by the DUT
	wordT modelMem [1 << `DADDR_WIDTH]; // ISA model copy
	wordT regs [32];
	wordT modelRegs [32];
	int kind [PROG_WORDS]; // 0 R, 1 I, 2 LW, 3 SW, 4 branch, 5 halt
	logic [2:0] f3 [PROG_WORDS];
	logic alt [PROG_WORDS]; // sub or sra
	regAddrT rd [PROG_WORDS];
	regAddrT rs1 [PROG_WORDS];
	regAddrT rs2 [PROG_WORDS];
	wordT imm [PROG_WORDS];
	rfWriteT expWrites [$]; // Ordered register writes from the model
	integer seed = 32'h638e;
	int modelRetired, writeIdx, seenWrites;
	int errTrace, errWrites, errRetired, errMem, errHalt;

	riscvTop dut (.CLK, .RSTn, .iMemAddr, .iMemData, .dMemReq, .dMemRdData, .rfRdAddr1,
		.rfRdAddr2, .rfRdData1, .rfRdData2, .rfWrite, .numInst, .halt);

	assign iMemData = iMem[iMemAddr[`PC_WIDTH-1:2]]; // Same cycle fetch
	assign dMemRdData = dMem[dMemReq.addr];
	assign rfRdData1 = regs[rfRdAddr1]; // No write-first bypass
	assign rfRdData2 = regs[rfRdAddr2];

	always @(posedge CLK) begin
		if (dMemReq.we) begin
			dMem[dMemReq.addr] <= dMemReq.wrData;
		end
		if (rfWrite.we) begin
			regs[rfWrite.addr] <= rfWrite.data;
		end
	end

	initial begin
		forever #10 CLK = ~CLK; // 20 ns period
	end

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// RV32I encodings
	function automatic wordT encR(input logic [2:0] fn, input logic a, input regAddrT d,
			input regAddrT s1, input regAddrT s2);
		return {1'b0, a, 5'b0, s2, s1, fn, d, 7'b0110011};
	endfunction

	function automatic wordT encI(input logic [6:0] opc, input logic [2:0] fn, input regAddrT d,
			input regAddrT s1, input logic [11:0] i12);
		return {i12, s1, fn, d, opc};
	endfunction

	function automatic wordT encS(input regAddrT s1, input regAddrT s2, input logic [11:0] i12);
		return {i12[11:5], s2, s1, 3'b010, i12[4:0], 7'b0100011};
	endfunction

	function automatic wordT encB(input logic [2:0] fn, input regAddrT s1, input regAddrT s2,
			input logic [12:0] off);
		return {off[12], off[10:5], s2, s1, fn, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic wordT aluRef(input logic [2:0] fn, input logic a, input wordT x,
			input wordT y);
		case (fn)
			3'b000: return a ? x - y : x + y;
			3'b001: return x << y[4:0];
			3'b010: return {31'b0, $signed(x) < $signed(y)};
			3'b011: return {31'b0, x < y};
			3'b100: return x ^ y;
			3'b101: begin
				if (a) begin
					return $signed(x) >>> y[4:0]; // Arithmetic keeps sign
				end else begin
					return x >> y[4:0];
				end
			end
			3'b110: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] fn, input wordT x, input wordT y);
		case (fn)
			3'b000: return x == y;
			3'b001: return x != y;
			3'b100: return $signed(x) < $signed(y);
			3'b101: return $signed(x) >= $signed(y);
			3'b110: return x < y;
			default: return x >= y; // BGEU
		endcase
	endfunction

	function automatic void modelWrite(input regAddrT dst, input wordT val);
		rfWriteT w;
		if (dst != '0) begin // x0 stays zero
			modelRegs[dst] = val;
			w.we = 1'b1;
			w.addr = dst;
			w.data = val;
			expWrites.push_back(w);
		end
	endfunction

	task automatic buildProgram();
		int sel;
		int off;
		logic [11:0] r12;
		for (int i = 0; i < (1 << (`PC_WIDTH - 2)); i++) begin
			iMem[i] = encI(7'b0010011, 3'b000, 5'd0, 5'd0, 12'(i)); // Nop tagged with its index
		end
		for (int i = 0; i < (1 << `DADDR_WIDTH); i++) begin
			dMem[i] = {12'(i), ~12'(i), 8'h5a}; // Address in both halves
			modelMem[i] = dMem[i];
		end
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			kind[i] = 1;
			f3[i] = 3'b000;
			alt[i] = 1'b0;
			rd[i] = 5'(1 + pick(7));
			rs1[i] = 5'(pick(8)); // Only x0..x7 so hazards are common
			rs2[i] = 5'(pick(8));
			r12 = 12'(pick(4096));
			imm[i] = {{20{r12[11]}}, r12};
			sel = pick(10);
			if (i < 7) begin
				rd[i] = 5'(i + 1); // ADDI xN, x0, imm
				rs1[i] = '0;
			end else if (i == HALT_IDX) begin
				kind[i] = 5;
			end else if (sel < 4) begin
				kind[i] = 0;
				f3[i] = 3'(pick(8));
				alt[i] = (f3[i] == 3'b000 || f3[i] == 3'b101) && (pick(2) == 1);
			end else if (sel < 6) begin
				f3[i] = 3'(pick(8));
				if (f3[i] == 3'b001 || f3[i] == 3'b101) begin // Shift immediates
					alt[i] = (f3[i] == 3'b101) && (pick(2) == 1);
					imm[i] = wordT'(pick(32)) | (alt[i] ? 32'h400 : 32'h0); // Bit 10 is instr[30]
				end
			end else if (sel < 8) begin
				kind[i] = (sel == 6) ? 2 : 3;
				rs1[i] = '0; // Absolute address in a 64-word window
				imm[i] = wordT'(4 * pick(64));
			end else begin
				kind[i] = 4;
				f3[i] = 3'(pick(6));
				if (f3[i] >= 3'd2) begin
					f3[i] = f3[i] + 3'd2; // Skip the two unused codes
				end
				off = 1 + pick(4);
				if (i + off > HALT_IDX) begin
					off = HALT_IDX - i; // Never jump past the halt
				end
				imm[i] = wordT'(4 * off);
			end
			case (kind[i])
				0: iMem[i] = encR(f3[i], alt[i], rd[i], rs1[i], rs2[i]);
				1: iMem[i] = encI(7'b0010011, f3[i], rd[i], rs1[i], imm[i][11:0]);
				2: iMem[i] = encI(7'b0000011, 3'b010, rd[i], rs1[i], imm[i][11:0]);
				3: iMem[i] = encS(rs1[i], rs2[i], imm[i][11:0]);
				4: iMem[i] = encB(f3[i], rs1[i], rs2[i], imm[i][12:0]);
				default: iMem[i] = `HALT_INSTR;
			endcase
		end
	endtask

	task automatic runModel();
		int pc;
		int nextPc;
		wordT a;
		wordT b;
		wordT ea;
		pc = 0;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		while (kind[pc] != 5) begin
			a = modelRegs[rs1[pc]];
			b = modelRegs[rs2[pc]];
			ea = a + imm[pc];
			nextPc = pc + 1;
			case (kind[pc])
				0: modelWrite(rd[pc], aluRef(f3[pc], alt[pc], a, b));
				1: modelWrite(rd[pc], aluRef(f3[pc], alt[pc], a, imm[pc]));
				2: modelWrite(rd[pc], modelMem[ea[`DADDR_WIDTH+1:2]]);
				3: modelMem[ea[`DADDR_WIDTH+1:2]] = b;
				default: begin
					if (branchTaken(f3[pc], a, b)) begin
						nextPc = pc + int'(imm[pc] >> 2);
					end
				end
			endcase
			modelRetired++; // Branches and stores retire too
			pc = nextPc;
		end
		modelRetired++; // Halt word counted
	endtask

	task automatic checkWrite();
		if (rfWrite.we) begin
			seenWrites++;
			assert (writeIdx < expWrites.size()) else begin
				$display("Register write to x%0d came after all expected writes", rfWrite.addr);
				errTrace++;
			end
			if (writeIdx < expWrites.size()) begin
				assert (rfWrite.addr == expWrites[writeIdx].addr
						&& rfWrite.data == expWrites[writeIdx].data) else begin
					$display("Mismatch at time %0t: write %0d got x%0d=%h, expected x%0d=%h", $time,
						writeIdx, rfWrite.addr, rfWrite.data, expWrites[writeIdx].addr,
						expWrites[writeIdx].data);
					errTrace++;
				end
				writeIdx++;
			end
		end
	endtask

	initial begin : mainFlow
		int cycles;
		int total;
		buildProgram();
		runModel();
		cycles = 0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTn = 1'b0; // Release on a falling edge
		while (!halt && cycles < TIMEOUT) begin
			checkWrite(); // rfWrite settles well before the next posedge
			@(negedge CLK);
			cycles++;
		end
		assert (halt) else begin
			$display("The program never halted within %0d cycles", TIMEOUT);
			errHalt++;
		end
		$display("Test 1 register write trace: %0d errors", errTrace);
		if (halt) begin
			assert (seenWrites == expWrites.size()) else begin
				$display("Mismatch at time %0t: %0d register writes seen, model expects %0d",
					$time, seenWrites, expWrites.size());
				errWrites++;
			end
			$display("Test 2 register write count: %0d errors", errWrites);
			assert (numInst == wordT'(modelRetired)) else begin
				$display("Mismatch at time %0t: numInst %0d, model retired %0d", $time, numInst,
					modelRetired);
				errRetired++;
			end
			$display("Test 3 retired count: %0d errors", errRetired);
			for (int i = 0; i < (1 << `DADDR_WIDTH); i++) begin
				assert (dMem[i] == modelMem[i]) else begin
					$display("Mismatch at time %0t: data word %0d is %h, expected %h", $time, i,
						dMem[i], modelMem[i]);
					errMem++;
				end
			end
			$display("Test 4 final data memory: %0d errors", errMem);
		end else begin
			$display("Tests 2 to 4 skipped because the core never halted");
		end
		$display("Test 5 halt before timeout: %0d errors", errHalt);
		total = errTrace + errWrites + errRetired + errMem + errHalt + dut.checks.failCount;
		$display("Summary: %0d check errors, %0d assertion failures, %0d cycles", total,
			dut.checks.failCount, cycles);
		if (total == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end
endmodule

//--- bench/riscv_assertions.sv
`timescale 1ns/1ps

module riscvAssertions (
	input logic CLK,
	input logic RSTn,
	input riscvPkg::pcT iMemAddr,
	input riscvPkg::rfWriteT rfWrite,
	input riscvPkg::wordT numInst,
	input logic halt,
	input riscvPkg::fetchPktT fetchPkt, // IF/ID register
	input riscvPkg::idExPktT idExQ, // ID/EX register
	input riscvPkg::redirectT redirect // Taken branch in EX
);
	int failCount = 0; // Failed assertion count

	// x0 is hardwired to zero
	noZeroWrite: assert property (@(posedge CLK) disable iff (RSTn)
		!(rfWrite.we && rfWrite.addr == '0)) else begin
		failCount++;
		$error("Register file write to x0");
	end

	haltSticky: assert property (@(posedge CLK) disable iff (RSTn) halt |=> halt) else begin
		failCount++;
		$error("halt dropped without reset");
	end

	countMonotonic: assert property (@(posedge CLK) disable iff (RSTn)
		numInst >= $past(numInst)) else begin
		failCount++;
		$error("numInst decreased");
	end

	// Taken branch fetches its target next and leaves bubbles in IF/ID and ID/EX
	redirectSquash: assert property (@(posedge CLK) disable iff (RSTn)
		redirect.taken |=> (iMemAddr == $past(redirect.target)) && !fetchPkt.valid
			&& !idExQ.valid) else begin
		failCount++;
		$error("Taken branch did not fetch its target and squash the younger words");
	end
endmodule

bind riscvTop riscvAssertions checks (.CLK, .RSTn, .iMemAddr, .rfWrite, .numInst, .halt,
	.fetchPkt, .idExQ, .redirect);

//--- src/decodeUnit.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module decodeUnit (
	input riscvPkg::fetchPktT fetchPkt,
	input logic flush, // Taken branch in EX
	output riscvPkg::regAddrT rfRdAddr1,
	output riscvPkg::regAddrT rfRdAddr2,
	input riscvPkg::wordT rfRdData1,
	input riscvPkg::wordT rfRdData2,
	input riscvPkg::idExPktT exPkt, // Older stages for interlock
	input riscvPkg::exMemPktT memPkt,
	input riscvPkg::memWbPktT wbPkt,
	output logic stall,
	output riscvPkg::idExPktT idExPkt
);
	import riscvPkg::*;

	wordT instr;
	regAddrT rs1, rs2;
	logic [2:0] funct3;
	wordT immI, immS, immB;
	logic useRs1, useRs2, isHalt;
	logic hazard, haltInFlight, live;
	idExPktT pkt;

	function automatic aluOpT aluFunc(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: aluFunc = alt ? aluSub : aluAdd;
			3'b001: aluFunc = aluSll;
			3'b010: aluFunc = aluSlt;
			3'b011: aluFunc = aluSltu;
			3'b100: aluFunc = aluXor;
			3'b101: aluFunc = alt ? aluSra : aluSrl;
			3'b110: aluFunc = aluOr;
			default: aluFunc = aluAnd;
		endcase
	endfunction

	// Pending write by an older payload
	function automatic logic pendingWrite(input logic v, input logic w, input regAddrT dst,
			input regAddrT src);
		return v && w && (dst == src) && (src != '0);
	endfunction

	assign instr = fetchPkt.instr;
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign funct3 = instr[14:12];
	assign rfRdAddr1 = rs1; // Register file reads combinationally
	assign rfRdAddr2 = rs2;

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb begin
		pkt = '0;
		pkt.pc = fetchPkt.pc;
		pkt.rd = instr[11:7];
		pkt.brFunct3 = funct3;
		pkt.aluOp = aluAdd; // Address add for memory ops
		pkt.opA = rfRdData1;
		pkt.opB = rfRdData2;
		pkt.imm = immI;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		isHalt = 1'b0;
		case (instr[6:0])
			OP: begin
				pkt.regWrite = 1'b1;
				pkt.aluOp = aluFunc(funct3, instr[30]); // funct7 bit picks sub/sra
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			OP_IMM: begin
				pkt.regWrite = 1'b1;
				pkt.useImm = 1'b1;
				pkt.aluOp = aluFunc(funct3, instr[30] && (funct3 == 3'b101)); // No subi
				useRs1 = 1'b1;
			end
			LOAD: begin
				pkt.regWrite = 1'b1;
				pkt.isLoad = 1'b1;
				pkt.useImm = 1'b1;
				useRs1 = 1'b1;
			end
			STORE: begin
				pkt.isStore = 1'b1;
				pkt.useImm = 1'b1;
				pkt.imm = immS;
				useRs1 = 1'b1;
				useRs2 = 1'b1; // Store data
			end
			BRANCH: begin
				pkt.isBranch = 1'b1;
				pkt.imm = immB;
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
			SYSTEM_RET: isHalt = (instr == `HALT_INSTR); // Other JALR forms act as nop
			default: ;
		endcase
		pkt.isHalt = isHalt;
	end

	assign hazard = (useRs1 && (pendingWrite(exPkt.valid, exPkt.regWrite, exPkt.rd, rs1)
			|| pendingWrite(memPkt.valid, memPkt.regWrite, memPkt.rd, rs1)
			|| pendingWrite(wbPkt.valid, wbPkt.regWrite, wbPkt.rd, rs1)))
		|| (useRs2 && (pendingWrite(exPkt.valid, exPkt.regWrite, exPkt.rd, rs2)
			|| pendingWrite(memPkt.valid, memPkt.regWrite, memPkt.rd, rs2)
			|| pendingWrite(wbPkt.valid, wbPkt.regWrite, wbPkt.rd, rs2)));

	// Halt already issued and still travelling
	assign haltInFlight = (exPkt.valid && exPkt.isHalt) || (memPkt.valid && memPkt.isHalt)
		|| (wbPkt.valid && wbPkt.isHalt);

	assign live = fetchPkt.valid && !flush; // Wrong path word is dropped
	assign stall = live && (hazard || isHalt); // Halt freezes fetch for good

	always_comb begin
		idExPkt = pkt;
		idExPkt.valid = live && !hazard && !(isHalt && haltInFlight); // Halt goes down once
	end
endmodule

//--- src/executeUnit.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module executeUnit (
	input riscvPkg::idExPktT idExPkt,
	output riscvPkg::redirectT redirect, // Valid in same cycle
	output riscvPkg::exMemPktT exMemPkt
);
	import riscvPkg::*;

	wordT aluB, result;
	logic condMet;

	assign aluB = idExPkt.useImm ? idExPkt.imm : idExPkt.opB;

	always_comb begin
		case (idExPkt.aluOp)
			aluAdd: result = idExPkt.opA + aluB;
			aluSub: result = idExPkt.opA - aluB;
			aluSll: result = idExPkt.opA << aluB[4:0];
			aluSlt: result = wordT'($signed(idExPkt.opA) < $signed(aluB));
			aluSltu: result = wordT'(idExPkt.opA < aluB);
			aluXor: result = idExPkt.opA ^ aluB;
			aluSrl: result = idExPkt.opA >> aluB[4:0];
			aluSra: result = $signed(idExPkt.opA) >>> aluB[4:0]; // Sign fill
			aluOr: result = idExPkt.opA | aluB;
			aluAnd: result = idExPkt.opA & aluB;
			default: result = '0;
		endcase
	end

	// Branch comparator on the raw register values
	always_comb begin
		case (idExPkt.brFunct3)
			3'b000: condMet = (idExPkt.opA == idExPkt.opB); // BEQ
			3'b001: condMet = (idExPkt.opA != idExPkt.opB); // BNE
			3'b100: condMet = ($signed(idExPkt.opA) < $signed(idExPkt.opB)); // BLT
			3'b101: condMet = ($signed(idExPkt.opA) >= $signed(idExPkt.opB)); // BGE
			3'b110: condMet = (idExPkt.opA < idExPkt.opB); // BLTU
			3'b111: condMet = (idExPkt.opA >= idExPkt.opB); // BGEU
			default: condMet = 1'b0;
		endcase
	end

	assign redirect.taken = idExPkt.valid && idExPkt.isBranch && condMet;
	assign redirect.target = idExPkt.pc + idExPkt.imm[`PC_WIDTH-1:0]; // PC relative

	assign exMemPkt = '{
		valid: idExPkt.valid,
		rd: idExPkt.rd,
		regWrite: idExPkt.regWrite,
		isLoad: idExPkt.isLoad,
		isStore: idExPkt.isStore,
		isHalt: idExPkt.isHalt,
		result: result,
		storeData: idExPkt.opB // rs2 straight through
	};
endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module fetchUnit (
	input logic CLK,
	input logic RSTn,
	input logic stall, // From decode interlock
	input riscvPkg::redirectT redirect, // Taken branch from EX
	output riscvPkg::pcT iMemAddr,
	input riscvPkg::wordT iMemData, // Same cycle answer
	output riscvPkg::fetchPktT fetchPkt // IF/ID register
);
	import riscvPkg::*;

	pcT pc;

	assign iMemAddr = pc; // PC drives memory directly

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= pcT'(`RESET_PC);
			fetchPkt <= '0;
		end else if (redirect.taken) begin
			pc <= redirect.target; // Target fetched next cycle
			fetchPkt <= '0; // Kill wrong path word
		end else if (!stall) begin
			pc <= pc + pcT'(4);
			fetchPkt <= '{valid: 1'b1, pc: pc, instr: iMemData};
		end
		// Stall keeps both PC and IF/ID
	end
endmodule

//--- src/memAccess.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module memAccess (
	input riscvPkg::exMemPktT exMemPkt,
	output riscvPkg::dMemReqT dMemReq,
	input riscvPkg::wordT dMemRdData, // Combinational read
	output riscvPkg::memWbPktT memWbPkt
);
	import riscvPkg::*;

	assign dMemReq.we = exMemPkt.valid && exMemPkt.isStore; // Bubbles never write
	assign dMemReq.addr = exMemPkt.result[`DADDR_WIDTH+1:2]; // Byte to word address
	assign dMemReq.wrData = exMemPkt.storeData;

	assign memWbPkt = '{
		valid: exMemPkt.valid,
		rd: exMemPkt.rd,
		regWrite: exMemPkt.regWrite,
		isHalt: exMemPkt.isHalt,
		wrData: exMemPkt.isLoad ? dMemRdData : exMemPkt.result
	};
endmodule

//--- src/riscvPkg.sv
`include "riscv_params.svh"

package riscvPkg;
	typedef logic [`XLEN-1:0] wordT;
	typedef logic [`PC_WIDTH-1:0] pcT; // Byte address
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	typedef enum logic [6:0] {
		OP = 7'b0110011, // Register ALU ops
		OP_IMM = 7'b0010011, // Immediate ALU ops
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		BRANCH = 7'b1100011,
		SYSTEM_RET = 7'b1100111 // Only the halt word is honoured
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu,
		aluXor, aluSrl, aluSra, aluOr, aluAnd
	} aluOpT;

	typedef struct packed {
		logic valid;
		pcT pc;
		wordT instr;
	} fetchPktT; // IF to ID

	typedef struct packed {
		logic valid;
		pcT pc; // Branch base
		regAddrT rd;
		logic regWrite;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic [2:0] brFunct3; // Branch condition select
		logic isHalt;
		aluOpT aluOp;
		logic useImm; // ALU B from immediate
		wordT opA; // rs1 value
		wordT opB; // rs2 value, also store data
		wordT imm;
	} idExPktT; // ID to EX

	typedef struct packed {
		logic valid;
		regAddrT rd;
		logic regWrite;
		logic isLoad;
		logic isStore;
		logic isHalt;
		wordT result; // ALU result or effective address
		wordT storeData;
	} exMemPktT; // EX to MEM

	typedef struct packed {
		logic valid;
		regAddrT rd;
		logic regWrite;
		logic isHalt;
		wordT wrData;
	} memWbPktT; // MEM to WB

	typedef struct packed {
		logic we;
		logic [`DADDR_WIDTH-1:0] addr; // Word address
		wordT wrData;
	} dMemReqT;

	typedef struct packed {
		logic we;
		regAddrT addr;
		wordT data;
	} rfWriteT;

	typedef struct packed {
		logic taken;
		pcT target;
	} redirectT;
endpackage

//--- src/riscvTop.sv
`timescale 1ns/1ps

module riscvTop (
	input logic CLK,
	input logic RSTn,
	output riscvPkg::pcT iMemAddr,
	input riscvPkg::wordT iMemData,
	output riscvPkg::dMemReqT dMemReq,
	input riscvPkg::wordT dMemRdData,
	output riscvPkg::regAddrT rfRdAddr1,
	output riscvPkg::regAddrT rfRdAddr2,
	input riscvPkg::wordT rfRdData1,
	input riscvPkg::wordT rfRdData2,
	output riscvPkg::rfWriteT rfWrite,
	output riscvPkg::wordT numInst,
	output logic halt
);
	import riscvPkg::*;

	fetchPktT fetchPkt; // IF/ID register output
	redirectT redirect;
	logic stall;
	idExPktT idExD, idExQ;
	exMemPktT exMemD, exMemQ;
	memWbPktT memWbD, memWbQ;

	fetchUnit fetch (.CLK, .RSTn, .stall, .redirect, .iMemAddr, .iMemData, .fetchPkt);

	decodeUnit decode (
		.fetchPkt,
		.flush(redirect.taken), // Squash ID on taken branch
		.rfRdAddr1,
		.rfRdAddr2,
		.rfRdData1,
		.rfRdData2,
		.exPkt(idExQ),
		.memPkt(exMemQ),
		.wbPkt(memWbQ),
		.stall,
		.idExPkt(idExD)
	);

	stageReg #(.payloadT(idExPktT)) idExReg (
		.CLK, .RSTn, .hold(1'b0), .flush(redirect.taken), .d(idExD), .q(idExQ)
	);

	executeUnit execute (.idExPkt(idExQ), .redirect, .exMemPkt(exMemD));

	stageReg #(.payloadT(exMemPktT)) exMemReg (
		.CLK, .RSTn, .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	memAccess mem (.exMemPkt(exMemQ), .dMemReq, .dMemRdData, .memWbPkt(memWbD));

	stageReg #(.payloadT(memWbPktT)) memWbReg (
		.CLK, .RSTn, .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	writeback wb (.CLK, .RSTn, .memWbPkt(memWbQ), .rfWrite, .numInst, .halt);
endmodule

//--- src/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Core widths
`define XLEN 32 // Data path width
`define PC_WIDTH 12 // Instruction memory byte address
`define DADDR_WIDTH 12 // Data memory word address
`define REG_ADDR_WIDTH 5 // x0..x31

// Program control
`define RESET_PC 0 // First fetch address
`define HALT_INSTR 32'h00008067 // Return word ends the program

`endif

//--- src/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic // Stage payload struct
) (
	input logic CLK,
	input logic RSTn,
	input logic hold, // Keep current payload
	input logic flush, // Replace with bubble
	input payloadT d,
	output payloadT q
);
	always_ff @(posedge CLK) begin
		if (RSTn || flush) begin
			q <= '0; // All zero means valid low
		end else if (!hold) begin
			q <= d;
		end
	end
endmodule

//--- src/writeback.sv
`timescale 1ns/1ps

module writeback (
	input logic CLK,
	input logic RSTn,
	input riscvPkg::memWbPktT memWbPkt,
	output riscvPkg::rfWriteT rfWrite, // Written at posedge ending WB
	output riscvPkg::wordT numInst, // Retired count
	output logic halt // Sticky until reset
);
	import riscvPkg::*;

	assign rfWrite.we = memWbPkt.valid && memWbPkt.regWrite && (memWbPkt.rd != '0);
	assign rfWrite.addr = memWbPkt.rd;
	assign rfWrite.data = memWbPkt.wrData;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			numInst <= '0;
			halt <= 1'b0;
		end else if (memWbPkt.valid && !halt) begin // Core frozen once halted
			numInst <= numInst + wordT'(1); // Halt word counts too
			if (memWbPkt.isHalt) begin
				halt <= 1'b1;
			end
		end
	end
endmodule

//--- tb.f
+incdir+src
src/riscvPkg.sv
src/stageReg.sv
src/fetchUnit.sv
src/decodeUnit.sv
src/executeUnit.sv
src/memAccess.sv
src/writeback.sv
src/riscvTop.sv
bench/riscv_assertions.sv
bench/riscvTb.sv
